// File: tb.f
+incdir+design
design/conv_pkg.sv
design/conv_ctrl.sv
design/axis_shift_buffer.sv
design/weight_store.sv
design/mac_array.sv
design/conv_engine_top.sv
testbench/conv_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= conv_engine_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/conv_engine_tb.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_engine_tb;

    localparam int DW      = `DATA_WIDTH;
    localparam int AW      = `ACC_WIDTH;
    localparam int UNITS   = `CONV_UNITS;
    localparam int PIXELS  = `BEAT_PIXELS;
    localparam int KW      = `KERNEL_H_WIDTH;
    localparam int CW      = `CH_IN_COUNTER_WIDTH;
    localparam int WW      = `WIN_COUNTER_WIDTH;
    localparam int TIMEOUT = 2000;                  // Cycles per wait

    typedef logic signed [AW-1:0] acc_t;
    typedef logic [AW*UNITS-1:0]  result_t;

    logic                          aclk;
    logic                          arst_n;
    logic                          start;
    logic [KW-1:0]                 kernel_h_1;
    logic [CW-1:0]                 channels_in_1;
    logic [WW-1:0]                 windows_1;
    logic                          w_we;
    logic [`W_ADDR_WIDTH-1:0]      w_addr;
    logic signed [DW-1:0]          w_wdata;
    logic [DW*PIXELS-1:0]          s_tdata;
    logic                          s_tvalid;
    logic                          s_tready;
    result_t                       r_tdata;
    logic                          r_tvalid;
    logic                          r_tready;
    logic                          busy;
    logic                          done;

    logic signed [DW-1:0]  w_mem [`W_DEPTH];          // Weights as written to the DUT
    logic signed [DW-1:0]  pix_mem [32][PIXELS];      // Beats of the window being sent
    result_t               exp_q[$];
    result_t               exp_res;
    result_t               data_prev;
    logic                  hold_prev;
    int                    hold_beats;
    int                    done_cnt;
    int                    results;
    int                    test_errs;
    int                    total_errs;
    int                    passed;
    int                    failed;
    bit                    aborted;
    bit                    bp_mode;

    conv_engine_top conv_engine_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // In bp_mode the host takes one result every 7 cycles
    initial begin
        int bp_cnt;
        bp_cnt   = 0;
        r_tready = 1'b1;
        forever begin
            @(posedge aclk);
            #1;
            r_tready = bp_mode ? (bp_cnt % 7 == 6) : 1'b1;
            bp_cnt++;
        end
    end

    // Lane u sums pixel(c, u+r) * weight(c*kh + r) over channels and rows
    function automatic result_t ref_window(input int kh, input int ch);
        result_t res;
        acc_t    sum;
        res = '0;
        for (int u = 0; u < UNITS; u++) begin
            sum = '0;
            for (int c = 0; c < ch; c++) begin
                for (int r = 0; r < kh; r++) begin
                    sum = sum + acc_t'(pix_mem[c][u+r]) * acc_t'(w_mem[c*kh+r]);
                end
            end
            res[u*AW +: AW] = sum;
        end
        return res;
    endfunction

    // Handshake signals are settled at the falling edge
    always @(negedge aclk) begin
        if (done) done_cnt++;
        if (hold_prev && r_tdata !== data_prev) begin
            $display("** Error r_tdata: changed from %h to %h while held", data_prev, r_tdata);
            test_errs++;
        end
        if (r_tvalid && !r_tready) begin
            if (s_tvalid && s_tready) hold_beats++;
            if (hold_beats == 2) begin
                $display("more than one input beat was accepted while a result was held");
                test_errs++;
            end
        end else begin
            hold_beats = 0;
        end
        if (r_tvalid && r_tready) begin
            if (exp_q.size() == 0) begin
                $display("a result arrived when no window was expected");
                test_errs++;
            end else begin
                exp_res = exp_q.pop_front();
                results++;
                if (r_tdata !== exp_res) begin
                    $display("** Error r_tdata: got %h expected %h", r_tdata, exp_res);
                    test_errs++;
                end
            end
        end
        hold_prev = r_tvalid && !r_tready;
        data_prev = r_tdata;
    end

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        test_errs++;
        aborted = 1'b1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_beat(input logic [DW*PIXELS-1:0] data);
        int t;
        t        = 0;
        s_tdata  = data;
        s_tvalid = 1'b1;
        @(negedge aclk);
        while (!s_tready && !aborted) begin
            t++;
            if (t > TIMEOUT) report_timeout("input beat was never accepted");
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        s_tvalid = 1'b0;
    endtask

    task automatic run_job(input int kh, input int ch, input int nwin, input bit stall);
        logic [DW*PIXELS-1:0] beat;
        int                   done_before;
        int                   t;
        for (int a = 0; a < kh * ch; a++) begin
            w_mem[a] = DW'($urandom);
            w_we     = 1'b1;
            w_addr   = a[`W_ADDR_WIDTH-1:0];
            w_wdata  = w_mem[a];
            @(posedge aclk);
            #1;
        end
        w_we          = 1'b0;
        done_before   = done_cnt;
        kernel_h_1    = KW'(kh - 1);
        channels_in_1 = CW'(ch - 1);
        windows_1     = WW'(nwin - 1);
        start         = 1'b1;
        @(posedge aclk);
        #1;
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        for (int w = 0; w < nwin && !aborted; w++) begin
            for (int c = 0; c < ch; c++) begin
                for (int p = 0; p < PIXELS; p++) pix_mem[c][p] = DW'($urandom);
            end
            exp_q.push_back(ref_window(kh, ch));
            for (int c = 0; c < ch && !aborted; c++) begin
                if (stall) begin
                    repeat ($urandom_range(0, 3)) begin
                        @(posedge aclk);
                        #1;
                    end
                end
                for (int p = 0; p < PIXELS; p++) beat[p*DW +: DW] = pix_mem[c][p];
                send_beat(beat);
            end
        end
        t = 0;
        while (done_cnt == done_before && !aborted) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) report_timeout("done never pulsed");
        end
        t = 0;
        while (exp_q.size() != 0 && !aborted) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT) report_timeout("expected results never arrived");
        end
        repeat (3) @(posedge aclk);
        #1;
        if (done_cnt != done_before + 1) begin
            $display("done pulsed %0d times in one job", done_cnt - done_before);
            test_errs++;
        end
        check_bit("busy", busy, 1'b0);
    endtask

    initial begin
        void'($urandom(33));
        {arst_n, start, w_we, s_tvalid} = '0;
        {kernel_h_1, channels_in_1, windows_1, w_addr, w_wdata, s_tdata} = '0;
        {done_cnt, results, test_errs, total_errs, passed, failed, hold_beats} = '0;
        {aborted, bp_mode, hold_prev} = '0;
        data_prev = '0;
        repeat (10) @(posedge aclk);
        #1;
        arst_n = 1'b1;

        // An offered beat is refused until start
        @(negedge aclk);
        check_bit("s_tready", s_tready, 1'b0);
        check_bit("r_tvalid", r_tvalid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        @(posedge aclk);
        #1;
        s_tvalid = 1'b1;
        repeat (5) begin
            @(negedge aclk);
            check_bit("s_tready", s_tready, 1'b0);
        end
        @(posedge aclk);
        #1;
        s_tvalid = 1'b0;
        close_test("reset state");

        run_job(1, 1, 1, 1'b0);
        close_test("single window, kernel 1, one channel");
        run_job(5, 5, 4, 1'b0);
        close_test("kernel 5, five channels");
        run_job(3, 4, 4, 1'b1);
        close_test("input stalls");
        bp_mode = 1'b1;
        run_job(5, 2, 4, 1'b1);
        bp_mode = 1'b0;
        close_test("output back-pressure");
        run_job(2, 3, 3, 1'b0);
        close_test("reconfiguration");

        $display("tests passed %0d, failed %0d, errors %0d, results checked %0d",
                 passed, failed, total_errs, results);
        if (failed == 0 && total_errs == 0 && !aborted) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/conv_engine_top.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_engine_top
    import conv_pkg::*;
(
    input  logic                                     aclk,
    input  logic                                     arst_n,
    input  logic                                     start,
    input  logic [`KERNEL_H_WIDTH-1:0]               kernel_h_1,
    input  logic [`CH_IN_COUNTER_WIDTH-1:0]          channels_in_1,
    input  logic [`WIN_COUNTER_WIDTH-1:0]            windows_1,
    input  logic                                     w_we,
    input  logic [`W_ADDR_WIDTH-1:0]                 w_addr,
    input  logic signed [`DATA_WIDTH-1:0]            w_wdata,
    input  logic [`DATA_WIDTH*`BEAT_PIXELS-1:0]      s_tdata,
    input  logic                                     s_tvalid,
    output logic                                     s_tready,
    output logic [`ACC_WIDTH*`CONV_UNITS-1:0]        r_tdata,
    output logic                                     r_tvalid,
    input  logic                                     r_tready,
    output logic                                     busy,
    output logic                                     done
);

    logic                                  run;
    logic [`KERNEL_H_WIDTH-1:0]            cfg_kernel_h_1;
    logic [`CH_IN_COUNTER_WIDTH-1:0]       cfg_channels_in_1;
    logic [`W_ADDR_WIDTH-1:0]              w_raddr;
    logic signed [`DATA_WIDTH-1:0]         w_rdata;
    mac_op_e                               mac_op;
    logic [`DATA_WIDTH*`CONV_UNITS-1:0]    v_tdata;
    logic                                  v_tvalid;
    logic                                  v_tready;
    logic                                  v_tlast;

    conv_ctrl conv_ctrl_i (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .start             (start),
        .kernel_h_1        (kernel_h_1),
        .channels_in_1     (channels_in_1),
        .windows_1         (windows_1),
        .v_tvalid          (v_tvalid),
        .v_tready          (v_tready),
        .v_tlast           (v_tlast),
        .run               (run),
        .cfg_kernel_h_1    (cfg_kernel_h_1),
        .cfg_channels_in_1 (cfg_channels_in_1),
        .w_raddr           (w_raddr),
        .mac_op            (mac_op),
        .busy              (busy),
        .done              (done)
    );

    axis_shift_buffer axis_shift_buffer_i (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .run           (run),
        .kernel_h_1    (cfg_kernel_h_1),
        .channels_in_1 (cfg_channels_in_1),
        .s_tdata       (s_tdata),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .v_tdata       (v_tdata),
        .v_tvalid      (v_tvalid),
        .v_tready      (v_tready),
        .v_tlast       (v_tlast)
    );

    weight_store weight_store_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .w_we    (w_we),
        .w_addr  (w_addr),
        .w_wdata (w_wdata),
        .w_raddr (w_raddr),
        .w_rdata (w_rdata)
    );

    mac_array mac_array_i (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .v_tdata  (v_tdata),
        .v_tvalid (v_tvalid),
        .v_tready (v_tready),
        .v_tlast  (v_tlast),
        .w_rdata  (w_rdata),
        .mac_op   (mac_op),
        .r_tdata  (r_tdata),
        .r_tvalid (r_tvalid),
        .r_tready (r_tready)
    );

endmodule

// File: design/mac_array.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module mac_array
    import conv_pkg::*;
(
    input  logic                                  aclk,
    input  logic                                  arst_n,
    input  logic [`DATA_WIDTH*`CONV_UNITS-1:0]    v_tdata,
    input  logic                                  v_tvalid,
    output logic                                  v_tready,
    input  logic                                  v_tlast,
    input  logic signed [`DATA_WIDTH-1:0]         w_rdata,
    input  mac_op_e                               mac_op,
    output logic [`ACC_WIDTH*`CONV_UNITS-1:0]     r_tdata,
    output logic                                  r_tvalid,
    input  logic                                  r_tready
);

    logic v_fire;
    logic win_end;

    // A held result blocks the view stream until the host takes it
    assign v_tready = ~r_tvalid | r_tready;
    assign v_fire   = v_tvalid & v_tready;
    assign win_end  = v_fire & v_tlast;

    for (genvar u = 0; u < `CONV_UNITS; u++) begin : g_lane
        logic signed [`DATA_WIDTH-1:0]   pix;
        logic signed [`ACC_WIDTH-1:0]    prod;
        logic signed [`ACC_WIDTH-1:0]    acc_next;
        logic signed [`ACC_WIDTH-1:0]    acc_q;
        logic signed [`ACC_WIDTH-1:0]    res_q;

        assign pix  = v_tdata[u*`DATA_WIDTH +: `DATA_WIDTH];
        assign prod = pix * w_rdata;                           // Sign extended to ACC_WIDTH

        always_comb begin
            if (mac_op == MAC_LOAD) begin
                acc_next = prod;
            end else begin
                acc_next = acc_q + prod;
            end
        end

        always_ff @(posedge aclk) begin
            if (v_fire) begin
                acc_q <= acc_next;
            end
            if (win_end) begin
                res_q <= acc_next;                             // Includes the final product
            end
        end

        assign r_tdata[u*`ACC_WIDTH +: `ACC_WIDTH] = res_q;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            r_tvalid <= 1'b0;
        end else if (win_end) begin
            r_tvalid <= 1'b1;
        end else if (r_tready) begin
            r_tvalid <= 1'b0;
        end
    end

endmodule

// File: design/weight_store.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module weight_store (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              w_we,
    input  logic [`W_ADDR_WIDTH-1:0]          w_addr,
    input  logic signed [`DATA_WIDTH-1:0]     w_wdata,
    input  logic [`W_ADDR_WIDTH-1:0]          w_raddr,
    output logic signed [`DATA_WIDTH-1:0]     w_rdata
);

    logic signed [`DATA_WIDTH-1:0] mem [`W_DEPTH];

    // Addresses past the array read as zero
    always_comb begin
        if (w_raddr < `W_DEPTH) begin
            w_rdata = mem[w_raddr];
        end else begin
            w_rdata = '0;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `W_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (w_we && (w_addr < `W_DEPTH)) begin
            mem[w_addr] <= w_wdata;
        end
    end

endmodule

// File: design/axis_shift_buffer.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module axis_shift_buffer (
    input  logic                                     aclk,
    input  logic                                     arst_n,
    input  logic                                     run,
    input  logic [`KERNEL_H_WIDTH-1:0]               kernel_h_1,
    input  logic [`CH_IN_COUNTER_WIDTH-1:0]          channels_in_1,
    input  logic [`DATA_WIDTH*`BEAT_PIXELS-1:0]      s_tdata,
    input  logic                                     s_tvalid,
    output logic                                     s_tready,
    output logic [`DATA_WIDTH*`CONV_UNITS-1:0]       v_tdata,
    output logic                                     v_tvalid,
    input  logic                                     v_tready,
    output logic                                     v_tlast
);

    localparam int VIEW_WIDTH = `DATA_WIDTH * `CONV_UNITS;

    logic [`DATA_WIDTH*`BEAT_PIXELS-1:0]   beat_q;
    logic                                  full_q;
    logic [`KERNEL_H_WIDTH-1:0]            shift_cnt;
    logic [`CH_IN_COUNTER_WIDTH-1:0]       ch_cnt;
    logic                                  last_shift;
    logic                                  last_ch;
    logic                                  v_fire;
    logic                                  s_fire;

    assign last_shift = (shift_cnt == kernel_h_1);
    assign last_ch    = (ch_cnt == channels_in_1);

    assign v_fire = full_q & v_tready;
    assign s_fire = s_tvalid & s_tready;

    // Take a new beat when empty or when the last view leaves this cycle
    assign s_tready = run & (~full_q | (v_fire & last_shift));

    assign v_tvalid = full_q;
    assign v_tlast  = full_q & last_shift & last_ch;
    assign v_tdata  = beat_q[shift_cnt*`DATA_WIDTH +: VIEW_WIDTH];   // View r starts at pixel r

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (s_fire) begin
            full_q <= 1'b1;
        end else if (v_fire && last_shift) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_fire) begin
            beat_q <= s_tdata;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            shift_cnt <= '0;
            ch_cnt    <= '0;
        end else if (v_fire) begin
            if (last_shift) begin
                shift_cnt <= '0;
                if (last_ch) begin
                    ch_cnt <= '0;          // Window complete
                end else begin
                    ch_cnt <= ch_cnt + 1'b1;
                end
            end else begin
                shift_cnt <= shift_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/conv_ctrl.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_ctrl
    import conv_pkg::*;
(
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              start,
    input  logic [`KERNEL_H_WIDTH-1:0]        kernel_h_1,
    input  logic [`CH_IN_COUNTER_WIDTH-1:0]   channels_in_1,
    input  logic [`WIN_COUNTER_WIDTH-1:0]     windows_1,
    input  logic                              v_tvalid,
    input  logic                              v_tready,
    input  logic                              v_tlast,
    output logic                              run,
    output logic [`KERNEL_H_WIDTH-1:0]        cfg_kernel_h_1,
    output logic [`CH_IN_COUNTER_WIDTH-1:0]   cfg_channels_in_1,
    output logic [`W_ADDR_WIDTH-1:0]          w_raddr,
    output mac_op_e                           mac_op,
    output logic                              busy,
    output logic                              done
);

    ctrl_state_e                     state_q;
    logic [`WIN_COUNTER_WIDTH-1:0]   cfg_windows_1;
    logic [`WIN_COUNTER_WIDTH-1:0]   win_cnt;
    logic                            view_fire;
    logic                            last_win;

    assign view_fire = v_tvalid & v_tready;
    assign last_win  = (win_cnt == cfg_windows_1);

    assign run    = (state_q == ST_RUN);
    assign busy   = run;
    assign mac_op = (w_raddr == '0) ? MAC_LOAD : MAC_ACC;   // First weight of a window loads

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q           <= ST_IDLE;
            cfg_kernel_h_1    <= '0;
            cfg_channels_in_1 <= '0;
            cfg_windows_1     <= '0;
            win_cnt           <= '0;
            w_raddr           <= '0;
            done              <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q           <= ST_RUN;
                        cfg_kernel_h_1    <= kernel_h_1;
                        cfg_channels_in_1 <= channels_in_1;
                        cfg_windows_1     <= windows_1;
                        win_cnt           <= '0;
                        w_raddr           <= '0;
                    end
                end
                ST_RUN: begin
                    if (view_fire) begin
                        if (v_tlast) begin
                            w_raddr <= '0;                // Next window restarts at channel 0, row 0
                            if (last_win) begin
                                state_q <= ST_IDLE;
                                done    <= 1'b1;
                            end else begin
                                win_cnt <= win_cnt + 1'b1;
                            end
                        end else begin
                            w_raddr <= w_raddr + 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/conv_pkg.sv
package conv_pkg;

    // Job state of the control module
    typedef enum logic {
        ST_IDLE = 1'b0,    // Waiting for start
        ST_RUN  = 1'b1     // Streaming views through the MAC bank
    } ctrl_state_e;

    // Accumulator opcode shared by all MAC lanes
    typedef enum logic {
        MAC_LOAD = 1'b0,   // Accumulator takes the product
        MAC_ACC  = 1'b1    // Accumulator adds the product
    } mac_op_e;

endpackage

// File: design/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Pixel and weight width
`define DATA_WIDTH 16

// Parallel output pixels, one MAC lane each
`define CONV_UNITS 8

// Largest kernel height supported by one beat
`define KERNEL_H_MAX 5
`define KERNEL_H_WIDTH 3

// Pixels carried by one input beat
`define BEAT_PIXELS (`CONV_UNITS + `KERNEL_H_MAX - 1)

`define CH_IN_COUNTER_WIDTH 5
`define WIN_COUNTER_WIDTH 16

`define ACC_WIDTH 40

// Weight memory, KERNEL_H_MAX rows for up to 32 channels
`define W_ADDR_WIDTH 8
`define W_DEPTH (`KERNEL_H_MAX * 32)

`endif
